// ==== dps_utim64.f ====
utim_pkg.sv
utim_bus_decode.sv
utim64.sv
utim_irq_result.sv
dps_utim64.sv
tb_clock_gen.sv
tb_dps_utim64.sv

// ==== Makefile ====
SIM      = verilator
TOP      = tb_dps_utim64
FILELIST = dps_utim64.f
FLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = test failed

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only --timing --timescale 1ns/100ps --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tb_dps_utim64.sv ====
module tb_dps_utim64;
	timeunit 1ns;
	timeprecision 100ps;
	import utim_pkg::*;

	localparam int SEED    = 65654;
	localparam int RB_N    = 40;
	localparam int CNT_N   = 20;
	localparam int CMP_N   = 6;
	localparam int IRQ_N   = 30;
	localparam int BURST_N = 80;
	// Bus operations and idle cycles that the tests schedule
	localparam int TOTAL_OPS = 2 * RB_N + 2 + 14 + 10 * CNT_N + 44 * CMP_N + 20
		+ 19 * IRQ_N + BURST_N + 8;
	localparam int CYCLE_LIMIT = 4 * TOTAL_OPS + 200;

	logic                   iCLOCK;
	logic                   inRESET;
	logic                   iTIMER_TICK = 1'b0;
	logic                   irq_ack = 1'b0;
	logic                   req_valid;
	logic                   req_rw;
	logic [UTIM_ADDR_W-1:0] req_addr;
	logic [UTIM_DATA_W-1:0] req_data;
	logic                   req_busy;
	logic                   resp_valid;
	logic [UTIM_DATA_W-1:0] resp_data;
	logic                   irq_valid;

	int         seed = SEED;
	int         line_seed = SEED + 1;
	int         cycles = 0;
	int         data_errors = 0;
	int         flag_errors = 0;
	int         line_errors = 0;
	int         proto_errors = 0;
	logic       tick_mode = 1'b0;
	logic       ack_mode = 1'b0;
	string      test_name = "reset";

	// Model of both timers, flags and interrupt line; timer t channel n at t*4+n
	logic [31:0] m_cfg [2];
	logic [63:0] m_count [2];
	logic [63:0] m_cmp [8];
	logic [31:0] m_ctl [8];
	logic [3:0]  m_irq [2];
	logic [7:0]  m_flags;
	logic        m_pend;
	logic        m_busy;
	logic        exp_valid;
	logic        exp_is_flags;
	logic [31:0] exp_data;

	tb_clock_gen clock_gen (.iCLOCK(iCLOCK), .inRESET(inRESET));

	dps_utim64 DUT (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .iTIMER_TICK(iTIMER_TICK),
		.req_valid(req_valid), .req_rw(req_rw), .req_addr(req_addr),
		.req_data(req_data), .irq_ack(irq_ack), .req_busy(req_busy),
		.resp_valid(resp_valid), .resp_data(resp_data), .irq_valid(irq_valid)
	);

	function automatic logic [4:0] reg_addr(input int t, input int i);
		return {t[0], i[3:0]};
	endfunction

	// Model readback by register map
	function automatic logic [31:0] model_read(input int t, input logic [3:0] i);
		int n;
		int k;
		n = t * 4 + (int'(i) - 3) / 3;
		k = (int'(i) - 3) % 3;
		if (i == REG_CONFIG) begin
			return m_cfg[t];
		end else if (i == REG_COUNT_LO) begin
			return m_count[t][31:0];
		end else if (i == REG_COUNT_HI) begin
			return m_count[t][63:32];
		end else if (i == 4'd15) begin
			return '0;
		end else if (k == 0) begin
			return m_cmp[n][31:0];
		end else if (k == 1) begin
			return m_cmp[n][63:32];
		end
		return m_ctl[n];
	endfunction

	task automatic check_data(input logic [UTIM_DATA_W-1:0] expected,
		input logic [UTIM_DATA_W-1:0] actual);
		if (actual !== expected) begin
			data_errors++;
			$display("FAIL %s: read data expected %h, actual %h", test_name, expected, actual);
		end
	endtask

	task automatic check_flags(input logic [UTIM_FLAG_W-1:0] expected,
		input logic [UTIM_FLAG_W-1:0] actual);
		if (actual !== expected) begin
			flag_errors++;
			$display("FAIL %s: flags expected %h, actual %h", test_name, expected, actual);
		end
	endtask

	task automatic check_irq(input logic expected, input logic actual);
		if (actual !== expected) begin
			line_errors++;
			$display("FAIL %s: irq_valid expected %b, actual %b", test_name, expected, actual);
		end
	endtask

	task automatic check_busy(input logic expected, input logic actual);
		if (actual !== expected) begin
			line_errors++;
			$display("FAIL %s: req_busy expected %b, actual %b", test_name, expected, actual);
		end
	endtask

	// Checks outputs before the edge, then steps the model through it
	always @(posedge iCLOCK) begin : model_step
		logic       accept;
		logic       wr;
		logic       bank;
		logic [3:0] ri;
		logic       is_flags;
		logic       flags_rd;
		logic [7:0] pulses;
		logic [3:0] match;
		logic [3:0] clr;
		if (!inRESET) begin
			for (int t = 0; t < 2; t++) begin
				m_cfg[t] <= '0;
				m_count[t] <= '0;
				m_irq[t] <= '0;
			end
			for (int n = 0; n < 8; n++) begin
				m_cmp[n] <= '0;
				m_ctl[n] <= '0;
			end
			m_flags <= '0;
			m_pend <= 1'b0;
			m_busy <= 1'b0;
			exp_valid <= 1'b0;
			exp_is_flags <= 1'b0;
			exp_data <= '0;
		end else begin
			check_busy(m_busy, req_busy);
			check_irq(m_pend, irq_valid);
			if (resp_valid && !exp_valid) begin
				proto_errors++;
				$display("%s: a response arrived with no read outstanding", test_name);
			end else if (!resp_valid && exp_valid) begin
				proto_errors++;
				$display("%s: a read got no response in the following cycle", test_name);
			end else if (resp_valid && exp_is_flags) begin
				check_flags(exp_data[7:0], resp_data[7:0]);
			end else if (resp_valid) begin
				check_data(exp_data, resp_data);
			end
			accept = req_valid && !m_busy;
			bank = req_addr[4];
			ri = req_addr[3:0];
			is_flags = (req_addr == FLAGS_ADDR);
			flags_rd = accept && !req_rw && is_flags;
			pulses = {m_irq[0], m_irq[1]};
			exp_valid <= accept && !req_rw;
			exp_is_flags <= is_flags;
			exp_data <= is_flags ? 32'(m_flags | pulses) : model_read(int'(bank), ri);
			m_busy <= (accept && !req_rw) || (m_busy && !exp_valid);
			m_flags <= flags_rd ? pulses : (m_flags | pulses);
			if (|pulses) begin
				m_pend <= 1'b1;
			end else if (irq_ack) begin
				m_pend <= 1'b0;
			end
			for (int t = 0; t < 2; t++) begin
				wr = accept && req_rw && (int'(bank) == t) && !is_flags;
				for (int n = 0; n < 4; n++) begin
					match[n] = m_ctl[t*4+n][0] && (m_count[t] == m_cmp[t*4+n]);
					clr[n] = m_ctl[t*4+n][1];
					if (wr && ri == 4'(3 + 3 * n)) m_cmp[t*4+n][31:0] <= req_data;
					if (wr && ri == 4'(4 + 3 * n)) m_cmp[t*4+n][63:32] <= req_data;
					if (wr && ri == 4'(5 + 3 * n)) m_ctl[t*4+n] <= req_data;
				end
				m_irq[t] <= match;
				if (wr && ri == REG_CONFIG) m_cfg[t] <= req_data;
				if (wr && ri == REG_COUNT_LO) begin
					m_count[t][31:0] <= req_data;
				end else if (wr && ri == REG_COUNT_HI) begin
					m_count[t][63:32] <= req_data;
				end else if (|(match & clr)) begin
					m_count[t] <= '0;
				end else if (m_cfg[t][0] && iTIMER_TICK) begin
					m_count[t] <= m_count[t] + 64'd1;
				end
			end
		end
	end

	// Tick and ack patterns
	always @(posedge iCLOCK) begin
		iTIMER_TICK <= tick_mode && 1'($random(line_seed));
		irq_ack <= ack_mode && 1'($random(line_seed));
	end

	always @(posedge iCLOCK) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the tests did not finish", cycles);
			$display("test failed");
			$finish;
		end
	end

	// Presents one request and holds it until accepted
	task automatic issue(input logic rw, input logic [4:0] addr, input logic [31:0] data);
		req_valid <= 1'b1;
		req_rw <= rw;
		req_addr <= addr;
		req_data <= data;
		@(posedge iCLOCK);
		while (req_busy) begin
			@(posedge iCLOCK);
		end
		req_valid <= 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge iCLOCK);
	endtask

	task automatic clear_controls();
		for (int t = 0; t < 2; t++) begin
			for (int n = 0; n < 4; n++) begin
				issue(1'b1, reg_addr(t, 5 + 3 * n), '0);
			end
		end
	endtask

	initial begin
		int t;
		int n;
		req_valid <= 1'b0;
		req_rw <= 1'b0;
		req_addr <= '0;
		req_data <= '0;
		@(posedge inRESET);
		@(posedge iCLOCK);

		test_name <= "readback";
		repeat (RB_N) begin
			t = {$random(seed)} % 2;
			n = {$random(seed)} % 15;
			issue(1'b1, reg_addr(t, n), $random(seed));
			issue(1'b0, reg_addr(t, n), '0);
		end
		issue(1'b1, 5'h0F, $random(seed));
		issue(1'b0, 5'h0F, '0);

		// Start just below the carry into the high word
		test_name <= "counting";
		tick_mode <= 1'b1;
		clear_controls();
		for (t = 0; t < 2; t++) begin
			issue(1'b1, reg_addr(t, 2), $random(seed));
			issue(1'b1, reg_addr(t, 1), 32'hFFFF_FFF0 - 32'({$random(seed)} % 16));
			issue(1'b1, reg_addr(t, 0), 32'd1);
		end
		repeat (CNT_N) begin
			t = {$random(seed)} % 2;
			idle({$random(seed)} % 8);
			issue(1'b0, reg_addr(t, 1), '0);
			issue(1'b0, reg_addr(t, 2), '0);
		end

		test_name <= "compare";
		repeat (CMP_N) begin
			for (t = 0; t < 2; t++) begin
				for (n = 0; n < 4; n++) begin
					issue(1'b1, reg_addr(t, 4 + 3 * n), m_count[t][63:32]);
					issue(1'b1, reg_addr(t, 3 + 3 * n),
						m_count[t][31:0] + 32'(16 + {$random(seed)} % 32));
					issue(1'b1, reg_addr(t, 5 + 3 * n), {30'd0, 1'($random(seed)), 1'b1});
				end
			end
			idle({$random(seed)} % 16);
			issue(1'b0, FLAGS_ADDR, '0);
			for (t = 0; t < 2; t++) begin
				issue(1'b0, reg_addr(t, 1), '0);
				issue(1'b0, reg_addr(t, 2), '0);
			end
		end

		// Timer A channel 2 matches a frozen count, then is switched off
		test_name <= "flag clear";
		tick_mode <= 1'b0;
		idle(3);
		clear_controls();
		issue(1'b1, reg_addr(0, 10), m_count[0][63:32]);
		issue(1'b1, reg_addr(0, 9), m_count[0][31:0]);
		issue(1'b1, reg_addr(0, 11), 32'd1);
		issue(1'b1, reg_addr(0, 11), 32'd0);
		idle(3);
		issue(1'b0, FLAGS_ADDR, '0);
		issue(1'b0, FLAGS_ADDR, '0);

		test_name <= "irq handshake";
		tick_mode <= 1'b1;
		ack_mode <= 1'b1;
		repeat (IRQ_N) begin
			t = {$random(seed)} % 2;
			n = {$random(seed)} % 4;
			issue(1'b1, reg_addr(t, 4 + 3 * n), m_count[t][63:32]);
			issue(1'b1, reg_addr(t, 3 + 3 * n), m_count[t][31:0] + 32'(2 + {$random(seed)} % 8));
			issue(1'b1, reg_addr(t, 5 + 3 * n), {30'd0, 1'($random(seed)), 1'b1});
			idle({$random(seed)} % 16);
			if (1'($random(seed))) begin
				issue(1'b0, FLAGS_ADDR, '0);
			end
		end

		test_name <= "burst";
		repeat (BURST_N) begin
			issue(1'($random(seed)), 5'($random(seed)), $random(seed));
		end

		tick_mode <= 1'b0;
		ack_mode <= 1'b0;
		idle(6);
		$display("errors: data %0d, flags %0d, handshake %0d, protocol %0d",
			data_errors, flag_errors, line_errors, proto_errors);
		if (data_errors + flag_errors + line_errors + proto_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen (
	output logic iCLOCK,
	output logic inRESET
);
	timeunit 1ns;
	timeprecision 100ps;

	// 4 ns period
	initial begin
		iCLOCK = 1'b0;
		forever #2 iCLOCK = ~iCLOCK;
	end

	// Three rising edges in reset, release on a falling edge
	initial begin
		inRESET <= 1'b0;
		repeat (3) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET <= 1'b1;
	end

endmodule

// ==== dps_utim64.sv ====
module dps_utim64 (
	input  logic                             iCLOCK,
	input  logic                             inRESET,
	input  logic                             iTIMER_TICK,
	input  logic                             req_valid,
	input  logic                             req_rw,
	input  logic [utim_pkg::UTIM_ADDR_W-1:0] req_addr,
	input  logic [utim_pkg::UTIM_DATA_W-1:0] req_data,
	input  logic                             irq_ack,
	output logic                             req_busy,
	output logic                             resp_valid,
	output logic [utim_pkg::UTIM_DATA_W-1:0] resp_data,
	output logic                             irq_valid
);
	import utim_pkg::*;

	logic                   tim_a_req;
	logic                   tim_b_req;
	logic                   flags_rd;
	logic [UTIM_IDX_W-1:0]  idx;
	logic                   rd_valid_a;
	logic                   rd_valid_b;
	logic [UTIM_DATA_W-1:0] rd_data_a;
	logic [UTIM_DATA_W-1:0] rd_data_b;
	logic [UTIM_CH_N-1:0]   irq_a;
	logic [UTIM_CH_N-1:0]   irq_b;

	utim_bus_decode decode (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.req_valid(req_valid), .req_rw(req_rw), .req_addr(req_addr),
		.resp_valid(resp_valid), .req_busy(req_busy),
		.tim_a_req(tim_a_req), .tim_b_req(tim_b_req),
		.flags_rd(flags_rd), .idx(idx)
	);

	// Both timers share index, direction and write data
	utim64 timer_a (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .iTIMER_TICK(iTIMER_TICK),
		.req(tim_a_req), .rw(req_rw), .idx(idx), .wdata(req_data),
		.rd_valid(rd_valid_a), .rd_data(rd_data_a), .irq(irq_a)
	);

	utim64 timer_b (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .iTIMER_TICK(iTIMER_TICK),
		.req(tim_b_req), .rw(req_rw), .idx(idx), .wdata(req_data),
		.rd_valid(rd_valid_b), .rd_data(rd_data_b), .irq(irq_b)
	);

	utim_irq_result result (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .flags_rd(flags_rd),
		.irq_a(irq_a), .irq_b(irq_b),
		.rd_valid_a(rd_valid_a), .rd_data_a(rd_data_a),
		.rd_valid_b(rd_valid_b), .rd_data_b(rd_data_b),
		.irq_ack(irq_ack), .irq_valid(irq_valid),
		.resp_valid(resp_valid), .resp_data(resp_data)
	);

endmodule

// ==== utim_irq_result.sv ====
module utim_irq_result (
	input  logic                             iCLOCK,
	input  logic                             inRESET,
	input  logic                             flags_rd,
	input  logic [utim_pkg::UTIM_CH_N-1:0]   irq_a,
	input  logic [utim_pkg::UTIM_CH_N-1:0]   irq_b,
	input  logic                             rd_valid_a,
	input  logic [utim_pkg::UTIM_DATA_W-1:0] rd_data_a,
	input  logic                             rd_valid_b,
	input  logic [utim_pkg::UTIM_DATA_W-1:0] rd_data_b,
	input  logic                             irq_ack,
	output logic                             irq_valid,
	output logic                             resp_valid,
	output logic [utim_pkg::UTIM_DATA_W-1:0] resp_data
);
	import utim_pkg::*;

	logic [UTIM_FLAG_W-1:0] pulses;
	logic [UTIM_FLAG_W-1:0] flags;
	logic [UTIM_FLAG_W-1:0] flag_buf;
	logic                   flag_buf_valid;
	logic                   irq_state;

	// Timer A in the upper nibble
	assign pulses = {irq_a, irq_b};

	// Read returns everything up to now and restarts from this cycle's pulses
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			flags          <= '0;
			flag_buf_valid <= 1'b0;
		end else begin
			flags          <= flags_rd ? pulses : (flags | pulses);
			flag_buf_valid <= flags_rd;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (flags_rd) begin
			flag_buf <= flags | pulses;
		end
	end

	// Line stays up until acked, a fresh match keeps it up
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			irq_state <= IRQ_IDLE;
		end else if (|pulses) begin
			irq_state <= IRQ_PEND;
		end else if (irq_ack) begin
			irq_state <= IRQ_IDLE;
		end
	end

	assign irq_valid = (irq_state == IRQ_PEND);

	// AND-OR merge of the three response sources
	assign resp_valid = rd_valid_a || rd_valid_b || flag_buf_valid;
	assign resp_data  = ({UTIM_DATA_W{rd_valid_a}} & rd_data_a)
		| ({UTIM_DATA_W{rd_valid_b}} & rd_data_b)
		| ({UTIM_DATA_W{flag_buf_valid}}
			& {{(UTIM_DATA_W-UTIM_FLAG_W){1'b0}}, flag_buf});

	// Decode lets one read through at a time, so sources never overlap
	a_single_source: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		$onehot0({rd_valid_a, rd_valid_b, flag_buf_valid})
	);

endmodule

// ==== utim64.sv ====
module utim64 (
	input  logic                             iCLOCK,
	input  logic                             inRESET,
	input  logic                             iTIMER_TICK,
	input  logic                             req,
	input  logic                             rw,
	input  logic [utim_pkg::UTIM_IDX_W-1:0]  idx,
	input  logic [utim_pkg::UTIM_DATA_W-1:0] wdata,
	output logic                             rd_valid,
	output logic [utim_pkg::UTIM_DATA_W-1:0] rd_data,
	output logic [utim_pkg::UTIM_CH_N-1:0]   irq
);
	import utim_pkg::*;

	logic [UTIM_DATA_W-1:0] cfg;
	logic [UTIM_CNT_W-1:0]  count;
	logic [UTIM_CNT_W-1:0]  cmp [UTIM_CH_N];
	logic [UTIM_DATA_W-1:0] ctl [UTIM_CH_N];
	logic [UTIM_CH_N-1:0]   ch_ie;
	logic [UTIM_CH_N-1:0]   ch_clr;
	logic [UTIM_CH_N-1:0]   match;
	logic [UTIM_DATA_W-1:0] rd_word;
	logic                   wr;

	assign wr = req && rw;

	// Compare every enabled channel against the live count
	always_comb begin
		for (int n = 0; n < UTIM_CH_N; n++) begin
			ch_ie[n]  = ctl[n][0];
			ch_clr[n] = ctl[n][1];
			match[n]  = ch_ie[n] && (count == cmp[n]);
		end
	end

	// Config, compare and control registers
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			cfg <= '0;
			for (int n = 0; n < UTIM_CH_N; n++) begin
				cmp[n] <= '0;
				ctl[n] <= '0;
			end
		end else if (wr) begin
			if (idx == REG_CONFIG) begin
				cfg <= wdata;
			end
			for (int n = 0; n < UTIM_CH_N; n++) begin
				if (idx == REG_CMP_BASE + UTIM_IDX_W'(3 * n)) begin
					cmp[n][UTIM_DATA_W-1:0] <= wdata;
				end
				if (idx == REG_CMP_BASE + UTIM_IDX_W'(3 * n + 1)) begin
					cmp[n][UTIM_CNT_W-1:UTIM_DATA_W] <= wdata;
				end
				if (idx == REG_CMP_BASE + UTIM_IDX_W'(3 * n + 2)) begin
					ctl[n] <= wdata;
				end
			end
		end
	end

	// Host write first, then clear-on-match, then the tick increment
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			count <= '0;
		end else if (wr && (idx == REG_COUNT_LO)) begin
			count[UTIM_DATA_W-1:0] <= wdata;
		end else if (wr && (idx == REG_COUNT_HI)) begin
			count[UTIM_CNT_W-1:UTIM_DATA_W] <= wdata;
		end else if (|(match & ch_clr)) begin
			count <= '0;
		end else if (cfg[0] && iTIMER_TICK) begin
			count <= count + UTIM_CNT_W'(1);
		end
	end

	// Match pulses come out one cycle after the compare
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			irq <= '0;
		end else begin
			irq <= match;
		end
	end

	// Readback mux, unused index 15 returns zero
	always_comb begin
		rd_word = '0;
		case (idx)
			REG_CONFIG:   rd_word = cfg;
			REG_COUNT_LO: rd_word = count[UTIM_DATA_W-1:0];
			REG_COUNT_HI: rd_word = count[UTIM_CNT_W-1:UTIM_DATA_W];
			default: begin
				for (int n = 0; n < UTIM_CH_N; n++) begin
					if (idx == REG_CMP_BASE + UTIM_IDX_W'(3 * n)) begin
						rd_word = cmp[n][UTIM_DATA_W-1:0];
					end
					if (idx == REG_CMP_BASE + UTIM_IDX_W'(3 * n + 1)) begin
						rd_word = cmp[n][UTIM_CNT_W-1:UTIM_DATA_W];
					end
					if (idx == REG_CMP_BASE + UTIM_IDX_W'(3 * n + 2)) begin
						rd_word = ctl[n];
					end
				end
			end
		endcase
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= req && !rw;
		end
	end

	// Capture the addressed register on a read
	always_ff @(posedge iCLOCK) begin
		if (req && !rw) begin
			rd_data <= rd_word;
		end
	end

	// A clearing match restarts the count unless the host writes it
	a_clear_restarts: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		(|(irq & $past(ch_clr))
			&& !$past(wr && ((idx == REG_COUNT_LO) || (idx == REG_COUNT_HI))))
			|-> (count == '0)
	);

endmodule

// ==== utim_bus_decode.sv ====
module utim_bus_decode (
	input  logic                             iCLOCK,
	input  logic                             inRESET,
	input  logic                             req_valid,
	input  logic                             req_rw,
	input  logic [utim_pkg::UTIM_ADDR_W-1:0] req_addr,
	input  logic                             resp_valid,
	output logic                             req_busy,
	output logic                             tim_a_req,
	output logic                             tim_b_req,
	output logic                             flags_rd,
	output logic [utim_pkg::UTIM_IDX_W-1:0]  idx
);
	import utim_pkg::*;

	logic state;
	logic accept;
	logic bank;
	logic is_flags;

	// Address split
	assign bank     = req_addr[UTIM_ADDR_W-1];
	assign idx      = req_addr[UTIM_IDX_W-1:0];
	assign is_flags = (req_addr == FLAGS_ADDR);

	// Only one read may be outstanding, writes pass freely
	assign req_busy = (state == DEC_RD_WAIT);
	assign accept   = req_valid && !req_busy;

	// Flag address belongs to neither timer; writes to it are dropped
	assign tim_a_req = accept && (bank == TIM_A_BANK);
	assign tim_b_req = accept && (bank == TIM_B_BANK) && !is_flags;
	assign flags_rd  = accept && is_flags && !req_rw;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= DEC_IDLE;
		end else begin
			case (state)
				DEC_IDLE: begin
					// Any accepted read, timer or flags, waits for its response
					if (accept && !req_rw) begin
						state <= DEC_RD_WAIT;
					end
				end
				DEC_RD_WAIT: begin
					if (resp_valid) begin
						state <= DEC_IDLE;
					end
				end
				default: begin
					state <= DEC_IDLE;
				end
			endcase
		end
	end

	// A response from the result stage always belongs to a pending read
	a_resp_only_when_waiting: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		resp_valid |-> (state == DEC_RD_WAIT)
	);

endmodule

// ==== utim_pkg.sv ====
package utim_pkg;

	// Bus and datapath widths
	localparam int UTIM_ADDR_W = 5;
	localparam int UTIM_DATA_W = 32;
	localparam int UTIM_IDX_W  = 4;
	localparam int UTIM_CNT_W  = 64;
	localparam int UTIM_CH_N   = 4;
	localparam int UTIM_FLAG_W = 8;

	// Register index inside one timer
	localparam logic [UTIM_IDX_W-1:0] REG_CONFIG   = 4'd0;
	localparam logic [UTIM_IDX_W-1:0] REG_COUNT_LO = 4'd1;
	localparam logic [UTIM_IDX_W-1:0] REG_COUNT_HI = 4'd2;
	// Channel n: compare lo, compare hi, control at base + 3n + 0..2
	localparam logic [UTIM_IDX_W-1:0] REG_CMP_BASE = 4'd3;

	// Address bit 4 picks the timer bank
	localparam logic TIM_A_BANK = 1'b0;
	localparam logic TIM_B_BANK = 1'b1;

	// Shared flag register, read clears
	localparam logic [UTIM_ADDR_W-1:0] FLAGS_ADDR = 5'h1F;

	// Bus front end states
	localparam logic DEC_IDLE    = 1'b0;
	localparam logic DEC_RD_WAIT = 1'b1;

	// Interrupt line states
	localparam logic IRQ_IDLE = 1'b0;
	localparam logic IRQ_PEND = 1'b1;

endpackage
